//--- project.f
verilog/hdmi_pkg.sv
verilog/video_timing.sv
verilog/stream_sync.sv
verilog/tmds_encoder.sv
verilog/hdmi_tx_top.sv
verification/hdmi_tx_tb.sv

//--- verification/hdmi_tx_tb.sv
`timescale 1ns/1ps
/* testbench for the HDMI transmitter
   streams frames from the data file, decodes the TMDS lanes and checks them */
module hdmi_tx_tb;
	import hdmi_pkg::*;

	localparam tmds_sym_t GUARD_BR = 10'b1011001100;
	localparam tmds_sym_t GUARD_G  = 10'b0100110011;

	logic i_pixclk, i_reset, i_valid, i_hlast, i_vlast;
	logic o_ready;
	pixel_t i_rgb_pix;
	hmode_t i_hmode;
	vmode_t i_vmode;
	tmds_sym_t o_red, o_grn, o_blu;

	// stream to send and pixels expected back, tagged by test
	pixel_t q_pix[$];
	logic q_hl[$], q_vl[$];
	pixel_t q_exp[$];
	int q_tid[$];
	int corrupt_line[$], corrupt_col[$];
	int errs[1:6];
	int n_checks;
	string test_names[1:6] = '{"reset and first frame", "sync timing", "guard and video periods",
		"clean frame data", "sync loss and resync", "running disparity"};

	hdmi_tx_top hdmi_tx_top_i (.*);

	initial
	begin
		i_pixclk = 1'b0;
		forever #5 i_pixclk = ~i_pixclk;
	end

	task check_value(input int test, input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (expected !== actual)
		begin
			$display("mismatch at %0t ns: %s expected %0h actual %0h", $time, name,
				expected, actual);
			errs[test]++;
		end
	endtask

	task abort_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$finish;
	endtask

	// control code {c1, c0}, -1 when not a control symbol
	function automatic int ctl_decode(input tmds_sym_t s);
		case (s)
			10'b1101010100: return 0;
			10'b0010101011: return 1;
			10'b0101010100: return 2;
			10'b1010101011: return 3;
			default:        return -1;
		endcase
	endfunction

	// inverse TMDS, bit 9 undoes inversion, bit 8 picks xor
	function automatic logic [7:0] decode_video(input tmds_sym_t s);
		logic [7:0] d;
		logic [7:0] q;
		d = s[9] ? ~s[7:0] : s[7:0];
		q[0] = d[0];
		for (int i = 1; i < 8; i++)
			q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
		return q;
	endfunction

	// ones minus zeros over the whole symbol
	function automatic int symbol_balance(input tmds_sym_t s);
		int n;
		n = 0;
		for (int i = 0; i < 10; i++)
			n += s[i];
		return 2 * n - 10;
	endfunction

	task build_stream;
		pixel_t p;
		int lc, cc;
		// first frame after reset, first line not seen by the monitor
		for (int i = 0; i < (i_vmode.width - 1) * i_hmode.width; i++)
		begin
			q_exp.push_back('0);
			q_tid.push_back(1);
		end
		for (int f = 0; f < corrupt_line.size(); f++)
			for (int r = 0; r < i_vmode.width; r++)
				for (int c = 0; c < i_hmode.width; c++)
				begin
					lc = corrupt_line[f];
					cc = corrupt_col[f];
					p = pixel_t'($urandom & 32'hffffff);
					q_pix.push_back(p);
					q_hl.push_back((lc >= 0 && r == lc) ? (c == cc) : (c == i_hmode.width - 1));
					q_vl.push_back(r == i_vmode.width - 1);
					// black from the misplaced mark to frame end
					q_exp.push_back((lc >= 0 && (r > lc || (r == lc && c > cc))) ? '0 : p);
					q_tid.push_back((lc >= 0 || (f > 0 && corrupt_line[f-1] >= 0)) ? 5 : 4);
				end
	endtask

	////////////////////////////////////////////////////////////
	// lane monitor
	////////////////////////////////////////////////////////////

	// 0 startup, 1 control, 2 guard, 3 video
	int state = 0, gcount, vcount, vlines, sym_idx, hs_run, vs_run, last_hs_rise = -1;
	// control symbols since video ended, -1 outside active lines
	int porch_cnt = -1;
	logic prev_hs, prev_vs, seen_vs;
	int disp[3];

	always @(negedge i_pixclk)
	begin
		int code;
		pixel_t px;
		tmds_sym_t syms[3];
		sym_idx++;
		code = ctl_decode(o_blu);
		if (i_reset)
			state = 0;
		else if (code >= 0)
		begin
			if (state == 3)
			begin
				check_value(3, "video length", i_hmode.width, vcount);
				porch_cnt = 0;
			end
			if (state == 2)
				check_value(3, "video symbols after guard", i_hmode.width, 0);
			if (porch_cnt >= 0)
				porch_cnt++;
			check_value(2, "grn control code", 1, ctl_decode(o_grn));
			check_value(2, "red control code", 0, ctl_decode(o_red));
			disp = '{0, 0, 0};
			// hsync in bit 0, vsync in bit 1
			if (code[0])
				hs_run++;
			if (code[0] && !prev_hs)
			begin
				if (last_hs_rise >= 0)
					check_value(2, "hsync period", i_hmode.raw, sym_idx - last_hs_rise);
				last_hs_rise = sym_idx;
				// front porch from video end to hsync
				if (porch_cnt > 0)
					check_value(2, "front porch", i_hmode.porch - i_hmode.width,
						porch_cnt - 1);
				porch_cnt = -1;
			end
			if (!code[0] && prev_hs && state != 0)
				check_value(2, "hsync width", i_hmode.synch - i_hmode.porch, hs_run);
			if (!code[0])
				hs_run = 0;
			vs_run = code[1] ? vs_run + 1 : vs_run;
			if (code[1] && !prev_vs)
			begin
				if (seen_vs)
					check_value(3, "video lines per frame", i_vmode.width, vlines);
				vlines = 0;
				seen_vs = 1'b1;
			end
			if (!code[1] && prev_vs)
				check_value(2, "vsync width",
					(i_vmode.synch - i_vmode.porch) * i_hmode.raw, vs_run);
			if (!code[1])
				vs_run = 0;
			prev_hs = code[0];
			prev_vs = code[1];
			state = 1;
		end
		else if (state == 1 || (state == 2 && gcount < 2))
		begin
			gcount = (state == 1) ? 1 : gcount + 1;
			state = 2;
			check_value(3, "blu guard", GUARD_BR, o_blu);
			check_value(3, "grn guard", GUARD_G, o_grn);
			check_value(3, "red guard", GUARD_BR, o_red);
		end
		else if (state != 0)
		begin
			if (state == 2)
			begin
				vcount = 0;
				vlines++;
			end
			state = 3;
			vcount++;
			px = {decode_video(o_red), decode_video(o_grn), decode_video(o_blu)};
			syms = '{o_blu, o_grn, o_red};
			for (int i = 0; i < 3; i++)
			begin
				// no running disparity, so bit 9 is the inverse of bit 8
				if (disp[i] == 0)
					check_value(6, "bit 9 at zero disparity", !syms[i][8], syms[i][9]);
				disp[i] += symbol_balance(syms[i]);
				check_value(6, "disparity within 10", 1, (disp[i] <= 10 && disp[i] >= -10));
			end
			if (q_exp.size() > 0)
				check_value(q_tid.pop_front(), "video pixel", q_exp.pop_front(), px);
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int fd, phase, a, b, c, d, k, idle, cyc, total;
		string line;
		logic accepted;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_hlast = 1'b0;
		i_vlast = 1'b0;
		i_rgb_pix = '0;
		i_hmode = '0;
		i_vmode = '0;
		void'($urandom(8528));
		fd = $fopen("verification/video_input.dat", "r");
		if (fd == 0)
			abort_run("cannot open the data file verification/video_input.dat");
		phase = 0;
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			void'($sscanf(line, "%d %d %d %d", a, b, c, d));
			if (phase == 0)
				i_hmode = '{width: a, porch: b, synch: c, raw: d};
			else if (phase == 1)
				i_vmode = '{width: a, porch: b, synch: c, raw: d};
			else
			begin
				corrupt_line.push_back(a);
				corrupt_col.push_back(b);
			end
			phase++;
		end
		$fclose(fd);
		build_stream();
		repeat (10) @(posedge i_pixclk);
		@(negedge i_pixclk);
		i_reset = 1'b0;
		// stream driver, one slot per falling edge
		k = 0;
		idle = 0;
		cyc = 0;
		accepted = 1'b0;
		while (k < q_pix.size())
		begin
			@(negedge i_pixclk);
			if (accepted)
			begin
				k++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > 1000)
					abort_run("stream stalled, no pixel accepted for 1000 clocks");
			end
			i_valid = (k < q_pix.size());
			if (k < q_pix.size())
			begin
				i_rgb_pix = q_pix[k];
				i_hlast = q_hl[k];
				i_vlast = q_vl[k];
			end
			#1;
			accepted = i_valid && o_ready;
			if (cyc < i_hmode.raw * i_vmode.raw)
				check_value(1, "o_ready in first frame", 0, o_ready);
			cyc++;
		end
		i_valid = 1'b0;
		idle = 0;
		while (q_exp.size() > 0)
		begin
			@(negedge i_pixclk);
			idle++;
			if (idle > 2000)
				abort_run("expected video never arrived on the TMDS lanes");
		end
		total = 0;
		for (int t = 1; t <= 6; t++)
		begin
			$display("test %0d %s: %s, %0d errors", t, test_names[t],
				errs[t] == 0 ? "ok" : "failed", errs[t]);
			total += errs[t];
		end
		$display("checks %0d, errors %0d", n_checks, total);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- verification/video_input.dat
# hmode: width porch synch raw (pixel clocks)
16 20 24 32
# vmode: height porch synch raw (lines)
4 5 6 8
# frames: corrupt line and misplaced hlast column, -1 -1 for a clean frame
-1 -1
-1 -1
2 7
-1 -1
-1 -1

//--- verilog/hdmi_pkg.sv
/* shared constants and types for the HDMI transmitter
   mode lines, pixel word, raster strobes and symbol period */
package hdmi_pkg;

	// width of every raster counter and mode field
	localparam int MODE_W = 12;
	// bits per colour component
	localparam int BPC = 8;
	// guard symbols ahead of each video period
	localparam logic [MODE_W-1:0] GUARD_PIXELS = MODE_W'(2);

	// one 24-bit pixel, red in the top byte
	typedef struct packed {
		logic [BPC-1:0] red;
		logic [BPC-1:0] grn;
		logic [BPC-1:0] blu;
	} pixel_t;

	// horizontal mode line, all in pixel clocks
	typedef struct packed {
		logic [MODE_W-1:0] width;
		logic [MODE_W-1:0] porch;
		logic [MODE_W-1:0] synch;
		logic [MODE_W-1:0] raw;
	} hmode_t;

	// vertical mode line, same fields counted in lines
	// width here is the number of active lines
	typedef struct packed {
		logic [MODE_W-1:0] width;
		logic [MODE_W-1:0] porch;
		logic [MODE_W-1:0] synch;
		logic [MODE_W-1:0] raw;
	} vmode_t;

	typedef enum logic [1:0] {
		PERIOD_GUARD = 2'b00,
		PERIOD_CTL   = 2'b01,
		PERIOD_VIDEO = 2'b11
	} period_e;

	typedef logic [9:0] tmds_sym_t;

	// raster strobes from the timing generator
	typedef struct packed {
		logic    hsync;
		logic    vsync;
		logic    newline;
		logic    newframe;
		logic    rd;
		period_e period;
	} raster_t;

endpackage

//--- verilog/hdmi_tx_top.sv
`timescale 1ns/1ps
/* DVI/HDMI transmitter top
   raster timing, stream tracking and three TMDS channels */
module hdmi_tx_top (
	input  logic                i_pixclk,
	input  logic                i_reset,
	input  logic                i_valid,
	output logic                o_ready,
	input  logic                i_hlast,
	input  logic                i_vlast,
	input  hdmi_pkg::pixel_t    i_rgb_pix,
	input  hdmi_pkg::hmode_t    i_hmode,
	input  hdmi_pkg::vmode_t    i_vmode,
	output hdmi_pkg::tmds_sym_t o_red,
	output hdmi_pkg::tmds_sym_t o_grn,
	output hdmi_pkg::tmds_sym_t o_blu
);
	import hdmi_pkg::*;

	// video preamble, c0 set on green only
	localparam logic [1:0] GRN_CTL = 2'b01;
	localparam logic [1:0] RED_CTL = 2'b00;

	logic    pix_reset;
	raster_t raster;
	pixel_t  pixel;

	video_timing video_timing_i (
		.i_pixclk    (i_pixclk),
		.i_reset     (i_reset),
		.i_hmode     (i_hmode),
		.i_vmode     (i_vmode),
		.o_pix_reset (pix_reset),
		.o_raster    (raster)
	);

	stream_sync stream_sync_i (
		.i_pixclk    (i_pixclk),
		.i_pix_reset (pix_reset),
		.i_raster    (raster),
		.i_valid     (i_valid),
		.i_hlast     (i_hlast),
		.i_vlast     (i_vlast),
		.i_rgb_pix   (i_rgb_pix),
		.o_ready     (o_ready),
		.o_pixel     (pixel)
	);

	// channel 0, blue carries the sync pair
	tmds_encoder #(.CHANNEL(0)) tmds_blu_i (
		.i_pixclk    (i_pixclk),
		.i_pix_reset (pix_reset),
		.i_period    (raster.period),
		.i_ctl       ({raster.vsync, raster.hsync}),
		.i_data      (pixel.blu),
		.o_symbol    (o_blu)
	);

	// channel 1, green
	tmds_encoder #(.CHANNEL(1)) tmds_grn_i (
		.i_pixclk    (i_pixclk),
		.i_pix_reset (pix_reset),
		.i_period    (raster.period),
		.i_ctl       (GRN_CTL),
		.i_data      (pixel.grn),
		.o_symbol    (o_grn)
	);

	// channel 2, red
	tmds_encoder #(.CHANNEL(2)) tmds_red_i (
		.i_pixclk    (i_pixclk),
		.i_pix_reset (pix_reset),
		.i_period    (raster.period),
		.i_ctl       (RED_CTL),
		.i_data      (pixel.red),
		.o_symbol    (o_red)
	);

endmodule

//--- verilog/stream_sync.sv
`timescale 1ns/1ps
/* pixel stream tracker
   checks the stream marks against the raster, flushes to frame end on
   loss of sync and sends black until back in step */
module stream_sync (
	input  logic              i_pixclk,
	input  logic              i_pix_reset,
	input  hdmi_pkg::raster_t i_raster,
	input  logic              i_valid,
	input  logic              i_hlast,
	input  logic              i_vlast,
	input  hdmi_pkg::pixel_t  i_rgb_pix,
	output logic              o_ready,
	output hdmi_pkg::pixel_t  o_pixel
);
	logic lost_sync;
	logic frame_end;
	logic resync;

	// end-of-frame mark on the stream
	assign frame_end = i_hlast && i_vlast;
	// eof pixel lands on the raster's last slot
	assign resync = i_valid && frame_end && i_raster.newframe;

	// loss on a missing pixel or on marks out of step
	always_ff @(posedge i_pixclk or posedge i_pix_reset)
	begin
		if (i_pix_reset)
			lost_sync <= 1'b0;
		else if (i_raster.rd)
		begin
			if (resync)
				lost_sync <= 1'b0;
			else if (!i_valid || (i_hlast != i_raster.newline)
					|| (frame_end != i_raster.newframe))
				lost_sync <= 1'b1;
		end
	end

	// in step, ready is the read strobe
	// out of step, drain up to the eof pixel and hold it for newframe
	always_comb
	begin
		if (!lost_sync)
			o_ready = i_raster.rd;
		else if (!frame_end)
			o_ready = 1'b1;
		else
			o_ready = i_raster.newframe;
	end

	// black outside reads, on a missing pixel and while lost
	always_ff @(posedge i_pixclk)
	begin
		if (i_raster.rd && i_valid && !lost_sync)
			o_pixel <= i_rgb_pix;
		else
			o_pixel <= '0;
	end

endmodule

//--- verilog/tmds_encoder.sv
`timescale 1ns/1ps
/* one TMDS channel
   DC-balanced video coding, control symbols and video guard band */
module tmds_encoder #(
	parameter int CHANNEL = 0
) (
	input  logic                i_pixclk,
	input  logic                i_pix_reset,
	input  hdmi_pkg::period_e   i_period,
	input  logic [1:0]          i_ctl,
	input  logic [7:0]          i_data,
	output hdmi_pkg::tmds_sym_t o_symbol
);
	import hdmi_pkg::*;

	// guard band, green differs from blue and red
	localparam tmds_sym_t GUARD_SYM = (CHANNEL == 1) ? 10'b0100110011 : 10'b1011001100;

	logic [3:0]        n1_data;
	logic              use_xnor;
	logic [8:0]        q_m;
	logic [3:0]        n1_qm;
	logic signed [4:0] qm_diff;
	logic signed [4:0] disparity;
	logic signed [4:0] disparity_next;
	tmds_sym_t         video_sym;
	tmds_sym_t         ctl_sym;

	////////////////////////////////////////////////////////////
	// transition minimizing stage
	////////////////////////////////////////////////////////////

	always_comb
	begin
		n1_data = '0;
		for (int i = 0; i < 8; i++)
			n1_data = n1_data + 4'(i_data[i]);
	end

	// xnor when ones dominate, tie broken on bit 0
	assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !i_data[0]);

	always_comb
	begin
		q_m[0] = i_data[0];
		for (int i = 1; i < 8; i++)
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
		// bit 8 marks xor coding
		q_m[8] = ~use_xnor;
	end

	////////////////////////////////////////////////////////////
	// DC balance
	////////////////////////////////////////////////////////////

	always_comb
	begin
		n1_qm = '0;
		for (int i = 0; i < 8; i++)
			n1_qm = n1_qm + 4'(q_m[i]);
	end

	// ones minus zeros over the low byte
	assign qm_diff = $signed({1'b0, n1_qm}) - $signed({1'b0, 4'd8 - n1_qm});

	always_comb
	begin
		if ((disparity == 0) || (qm_diff == 0))
		begin
			video_sym      = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
			disparity_next = q_m[8] ? disparity + qm_diff : disparity - qm_diff;
		end
		else if (((disparity > 0) && (qm_diff > 0)) || ((disparity < 0) && (qm_diff < 0)))
		begin
			// invert the byte to pull back toward zero
			video_sym      = {1'b1, q_m[8], ~q_m[7:0]};
			disparity_next = disparity - qm_diff + (q_m[8] ? 5'sd2 : 5'sd0);
		end
		else
		begin
			video_sym      = {1'b0, q_m[8], q_m[7:0]};
			disparity_next = disparity + qm_diff - (q_m[8] ? 5'sd0 : 5'sd2);
		end
	end

	// control symbols, i_ctl is {c1, c0}
	always_comb
	begin
		case (i_ctl)
			2'b00:   ctl_sym = 10'b1101010100;
			2'b01:   ctl_sym = 10'b0010101011;
			2'b10:   ctl_sym = 10'b0101010100;
			default: ctl_sym = 10'b1010101011;
		endcase
	end

	// output stage
	// disparity restarts at every control period
	always_ff @(posedge i_pixclk or posedge i_pix_reset)
	begin
		if (i_pix_reset)
		begin
			disparity <= '0;
			o_symbol  <= GUARD_SYM;
		end
		else
		begin
			case (i_period)
				PERIOD_VIDEO:
				begin
					o_symbol  <= video_sym;
					disparity <= disparity_next;
				end
				PERIOD_CTL:
				begin
					o_symbol  <= ctl_sym;
					disparity <= '0;
				end
				default:
					o_symbol <= GUARD_SYM;
			endcase
		end
	end

endmodule

//--- verilog/video_timing.sv
`timescale 1ns/1ps
/* raster timing generator
   releases the pixel reset, runs the counters and registers sync,
   stream marks, read strobe and symbol period for the encoders */
module video_timing (
	input  logic              i_pixclk,
	input  logic              i_reset,
	input  hdmi_pkg::hmode_t  i_hmode,
	input  hdmi_pkg::vmode_t  i_vmode,
	output logic              o_pix_reset,
	output hdmi_pkg::raster_t o_raster
);
	import hdmi_pkg::*;

	logic [1:0]        reset_pipe;
	logic [MODE_W-1:0] hpos;
	logic [MODE_W-1:0] vpos;
	logic              active_line;
	logic              first_frame;
	period_e           period_class;
	period_e           period_next;
	// {vsync, hsync} one stage ahead of the raster
	logic [1:0]        sync_next;

	////////////////////////////////////////////////////////////
	// reset release
	////////////////////////////////////////////////////////////

	// assert at once, release after three pixel clocks
	always_ff @(posedge i_pixclk or posedge i_reset)
	begin
		if (i_reset)
		begin
			reset_pipe  <= 2'b11;
			o_pix_reset <= 1'b1;
		end
		else
		begin
			reset_pipe  <= {reset_pipe[0], 1'b0};
			o_pix_reset <= reset_pipe[1];
		end
	end

	////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////

	// pixel count within the line, 0 .. raw-1
	always_ff @(posedge i_pixclk or posedge o_pix_reset)
	begin
		if (o_pix_reset)
			hpos <= '0;
		else if (hpos >= i_hmode.raw - 1'b1)
			hpos <= '0;
		else
			hpos <= hpos + 1'b1;
	end

	// line count, steps as the line passes its porch
	// so the new line number is seen with the hsync edge
	always_ff @(posedge i_pixclk or posedge o_pix_reset)
	begin
		if (o_pix_reset)
			vpos <= '0;
		else if (hpos == i_hmode.porch - 1'b1)
		begin
			if (vpos >= i_vmode.raw - 1'b1)
				vpos <= '0;
			else
				vpos <= vpos + 1'b1;
		end
	end

	assign active_line = (vpos < i_vmode.width);

	// no pixels read until one full frame has gone by
	always_ff @(posedge i_pixclk or posedge o_pix_reset)
	begin
		if (o_pix_reset)
			first_frame <= 1'b1;
		else if (o_raster.newframe)
			first_frame <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// period classification
	////////////////////////////////////////////////////////////

	// guard slots sit at the line end, where vpos already
	// names the line whose video follows
	always_comb
	begin
		if (!active_line)
			period_class = PERIOD_CTL;
		else if (hpos < i_hmode.width)
			period_class = PERIOD_VIDEO;
		else if (hpos >= i_hmode.raw - GUARD_PIXELS)
			period_class = PERIOD_GUARD;
		else
			period_class = PERIOD_CTL;
	end

	// registered outputs
	// period and sync pair go through one extra stage to line up
	// with the captured pixel in stream_sync
	always_ff @(posedge i_pixclk or posedge o_pix_reset)
	begin
		if (o_pix_reset)
		begin
			period_next       <= PERIOD_GUARD;
			sync_next         <= 2'b00;
			o_raster.hsync    <= 1'b0;
			o_raster.vsync    <= 1'b0;
			o_raster.newline  <= 1'b0;
			o_raster.newframe <= 1'b0;
			o_raster.rd       <= 1'b0;
			o_raster.period   <= PERIOD_GUARD;
		end
		else
		begin
			period_next       <= period_class;
			sync_next         <= {(vpos >= i_vmode.porch) && (vpos < i_vmode.synch),
				(hpos >= i_hmode.porch) && (hpos < i_hmode.synch)};
			o_raster.hsync    <= sync_next[0];
			o_raster.vsync    <= sync_next[1];
			// last pixel of an active line
			o_raster.newline  <= (hpos == i_hmode.width - 1'b1) && active_line;
			// last pixel of the last active line
			o_raster.newframe <= (hpos == i_hmode.width - 1'b1)
				&& (vpos == i_vmode.width - 1'b1);
			o_raster.rd       <= (hpos < i_hmode.width) && active_line && !first_frame;
			o_raster.period   <= period_next;
		end
	end

endmodule
